// File: mvbTcam.f
+incdir+include
verilog/tcamPkg.sv
verilog/tcamAccessCtrl.sv
verilog/tcamStorage.sv
verilog/tcamMatchLane.sv
verilog/mvbTcam.sv
tests/tbMvbTcam.sv

// File: run.sh
#!/usr/bin/env bash
# build the mvbTcam testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tbMvbTcam \
    -f mvbTcam.f -o simMvbTcam > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/simMvbTcam > sim.log 2>&1
simStatus=$?
cat sim.log

grep -q "Errors found" sim.log && { echo "simulation failed"; exit 1; }
[ "$simStatus" -eq 0 ] || { echo "simulation ended abnormally"; exit 1; }
echo "simulation passed"

// File: include/tcamRefModel.svh
// reference model of the TCAM entry array
// ternary match with lowest-index priority, zero read of unwritten entries

`ifndef TCAM_REF_MODEL_SVH
`define TCAM_REF_MODEL_SVH

logic [DATA_WIDTH-1:0] refData  [ITEMS];
logic [DATA_WIDTH-1:0] refMask  [ITEMS];
logic                  refValid [ITEMS];

// every entry invalid, as after reset
function automatic void clearEntries();
    for (int i = 0; i < ITEMS; i++) begin
        refData[i]  = '0;
        refMask[i]  = '0;
        refValid[i] = 1'b0;
    end
endfunction

function automatic void storeEntry(input logic [ADDR_WIDTH-1:0] addr,
                                   input logic [DATA_WIDTH-1:0] wData,
                                   input logic [DATA_WIDTH-1:0] wMask);
    refData[addr]  = wData;
    refMask[addr]  = wMask;
    refValid[addr] = 1'b1;
endfunction

function automatic void readEntry(input  logic [ADDR_WIDTH-1:0] addr,
                                  output logic [DATA_WIDTH-1:0] rData,
                                  output logic [DATA_WIDTH-1:0] rMask);
    rData = refValid[addr] ? refData[addr] : '0;
    rMask = refValid[addr] ? refMask[addr] : '0;
endfunction

// care bits of key and entry agree, no hit gives address zero
function automatic void matchKey(input  logic [DATA_WIDTH-1:0] key,
                                 output logic                  hit,
                                 output logic [ADDR_WIDTH-1:0] addr);
    hit  = 1'b0;
    addr = '0;
    for (int i = 0; i < ITEMS; i++) begin
        if (!hit && refValid[i] && ((key & refMask[i]) == (refData[i] & refMask[i]))) begin
            hit  = 1'b1;
            addr = ADDR_WIDTH'(i);
        end
    end
endfunction

`endif

// File: tests/tbMvbTcam.sv
// testbench for the TCAM with a multi-item match bus
// clock, reset, request stimulus, reference-model expectations
// concurrent checks of all DUT outputs, watchdog and closing report

`timescale 1ns/1ps
`default_nettype none

module tbMvbTcam import tcamPkg::*; ();

    `include "tcamRefModel.svh"

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_MATCH    = 24;
    localparam int NUM_FILL     = 16;
    localparam int NUM_CONTEND  = 3;
    localparam int RAND_CYCLES  = 400;
    // contended requests take two cycles at most
    localparam int STIM_CYCLES  = RESET_CYCLES + 4 + NUM_MATCH + 2 * NUM_FILL
                                  + 2 * NUM_CONTEND + 2 * RAND_CYCLES + MATCH_LATENCY + 2;
    localparam logic [DATA_WIDTH-1:0] MASKS [4] = '{16'hFFFF, 16'hFF00, 16'hFFF0, 16'hF0F0};

    typedef struct packed {
        int unsigned           due;
        logic [DATA_WIDTH-1:0] data;
        logic [DATA_WIDTH-1:0] mask;
    } readExp_t;

    typedef struct packed {
        int unsigned                         due;
        logic [MVB_ITEMS-1:0]                vld;
        logic [MVB_ITEMS-1:0]                hit;
        logic [MVB_ITEMS-1:0][ADDR_WIDTH-1:0] addr;
    } matchExp_t;

    logic                                 CLK;
    logic                                 arstN;
    logic                                 writeEn;
    logic [DATA_WIDTH-1:0]                writeData;
    logic [DATA_WIDTH-1:0]                writeMask;
    logic [ADDR_WIDTH-1:0]                writeAddr;
    logic                                 writeRdy;
    logic                                 readEn;
    logic [ADDR_WIDTH-1:0]                readAddr;
    logic                                 readRdy;
    logic [DATA_WIDTH-1:0]                readData;
    logic [DATA_WIDTH-1:0]                readMask;
    logic                                 readDataVld;
    logic                                 matchSrcRdy;
    logic [MVB_ITEMS-1:0][DATA_WIDTH-1:0] matchData;
    logic [MVB_ITEMS-1:0]                 matchVld;
    logic                                 matchRdy;
    logic                                 matchOutSrcRdy;
    logic [MVB_ITEMS-1:0]                 matchOutVld;
    logic [MVB_ITEMS-1:0]                 matchOutHit;
    logic [MVB_ITEMS-1:0][ADDR_WIDTH-1:0] matchOutAddr;

    int          errCount = 0;
    int unsigned edgeCnt;
    readExp_t    readQ [$];
    matchExp_t   matchQ [$];
    readExp_t    expRd       = '0;
    logic        expRdVld    = 1'b0;
    matchExp_t   expMatch    = '0;
    logic        expMoSrcRdy = 1'b0;

    mvbTcam i_mvbTcam (.*);

    initial begin : clockGen
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // expectations for the edge after this one
    always @(posedge CLK or negedge arstN) begin : monitor
        logic [DATA_WIDTH-1:0] rdData;
        logic [DATA_WIDTH-1:0] rdMask;
        logic                  hitK;
        logic [ADDR_WIDTH-1:0] addrK;
        readExp_t              rExp;
        matchExp_t             mExp;
        if (!arstN) begin
            clearEntries();
            edgeCnt     <= 0;
            expRd       <= '0;
            expRdVld    <= 1'b0;
            expMatch    <= '0;
            expMoSrcRdy <= 1'b0;
        end else begin
            // reads and matches see the entries as they were before this edge
            if (readEn && readRdy) begin
                readEntry(readAddr, rdData, rdMask);
                rExp.due  = edgeCnt + 1;
                rExp.data = rdData;
                rExp.mask = rdMask;
                readQ.push_back(rExp);
            end
            if (matchSrcRdy && matchRdy) begin
                mExp.due = edgeCnt + MATCH_LATENCY;
                mExp.vld = matchVld;
                for (int k = 0; k < MVB_ITEMS; k++) begin
                    matchKey(matchData[k], hitK, addrK);
                    mExp.hit[k]  = hitK;
                    mExp.addr[k] = addrK;
                end
                matchQ.push_back(mExp);
            end
            if (writeEn && writeRdy) begin
                storeEntry(writeAddr, writeData, writeMask);
            end
            if (readQ.size() != 0 && readQ[0].due == edgeCnt + 1) begin
                expRd    <= readQ[0];
                expRdVld <= 1'b1;
                void'(readQ.pop_front());
            end else begin
                expRdVld <= 1'b0;
            end
            if (matchQ.size() != 0 && matchQ[0].due == edgeCnt + 1) begin
                expMatch    <= matchQ[0];
                expMoSrcRdy <= 1'b1;
                void'(matchQ.pop_front());
            end else begin
                expMatch    <= '0;
                expMoSrcRdy <= 1'b0;
            end
            edgeCnt <= edgeCnt + 1;
        end
    end

    task automatic reportMismatch(input string name, input logic [31:0] expVal,
                                  input logic [31:0] actVal);
        errCount++;
        $display("CHECK FAILED at %0t: %s expected %0h, got %0h", $time, name, expVal, actVal);
    endtask

    assert property (@(posedge CLK) readDataVld == expRdVld)
        else reportMismatch("readDataVld", 32'($sampled(expRdVld)), 32'($sampled(readDataVld)));
    assert property (@(posedge CLK) expRdVld |-> readData == expRd.data)
        else reportMismatch("readData", 32'($sampled(expRd.data)), 32'($sampled(readData)));
    assert property (@(posedge CLK) expRdVld |-> readMask == expRd.mask)
        else reportMismatch("readMask", 32'($sampled(expRd.mask)), 32'($sampled(readMask)));
    assert property (@(posedge CLK) matchOutSrcRdy == expMoSrcRdy)
        else reportMismatch("matchOutSrcRdy", 32'($sampled(expMoSrcRdy)),
                            32'($sampled(matchOutSrcRdy)));
    assert property (@(posedge CLK) matchOutVld == expMatch.vld)
        else reportMismatch("matchOutVld", 32'($sampled(expMatch.vld)), 32'($sampled(matchOutVld)));
    assert property (@(posedge CLK) expMoSrcRdy |-> matchOutHit == expMatch.hit)
        else reportMismatch("matchOutHit", 32'($sampled(expMatch.hit)), 32'($sampled(matchOutHit)));
    assert property (@(posedge CLK) expMoSrcRdy |-> matchOutAddr == expMatch.addr)
        else reportMismatch("matchOutAddr", 32'($sampled(expMatch.addr)),
                            32'($sampled(matchOutAddr)));
    // writes are never held off, and a write holds off both read and match
    assert property (@(posedge CLK) writeRdy)
        else reportMismatch("writeRdy", 32'(1), 32'($sampled(writeRdy)));
    assert property (@(posedge CLK) readRdy == !writeEn)
        else reportMismatch("readRdy", 32'(!$sampled(writeEn)), 32'($sampled(readRdy)));
    assert property (@(posedge CLK) matchRdy == !writeEn)
        else reportMismatch("matchRdy", 32'(!$sampled(writeEn)), 32'($sampled(matchRdy)));

    function automatic logic [DATA_WIDTH-1:0] pickKey();
        logic [7:0] low;
        low = 8'($urandom);
        case ($urandom_range(3))
            0:       return 16'hA5A5;
            1:       return {8'h12, low};
            2:       return {12'h12F, low[3:0]};
            default: return DATA_WIDTH'($urandom);
        endcase
    endfunction

    task automatic loadWrite(input logic [ADDR_WIDTH-1:0] addr,
                             input logic [DATA_WIDTH-1:0] data,
                             input logic [DATA_WIDTH-1:0] mask);
        writeAddr = addr;
        writeData = data;
        writeMask = mask;
    endtask

    // hold each request until its ready was seen at a rising edge
    task automatic issue(input bit doWrite, input bit doRead, input bit doMatch);
        bit wAcc;
        bit rAcc;
        bit mAcc;
        writeEn     = doWrite;
        readEn      = doRead;
        matchSrcRdy = doMatch;
        while (writeEn || readEn || matchSrcRdy) begin
            @(negedge CLK);
            wAcc = writeEn && writeRdy;
            rAcc = readEn && readRdy;
            mAcc = matchSrcRdy && matchRdy;
            if (wAcc) writeEn = 1'b0;
            if (rAcc) readEn = 1'b0;
            if (mAcc) matchSrcRdy = 1'b0;
        end
    endtask

    initial begin : stimulus
        logic [ADDR_WIDTH-1:0] fillAddr [NUM_FILL];
        bit                    doW;
        bit                    doR;
        bit                    doM;
        void'($urandom(32'h56fc));
        arstN       = 1'b0;
        writeEn     = 1'b0;
        writeData   = '0;
        writeMask   = '0;
        writeAddr   = '0;
        readEn      = 1'b0;
        readAddr    = '0;
        matchSrcRdy = 1'b0;
        matchData   = '0;
        matchVld    = '0;
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        arstN = 1'b1;
        @(negedge CLK);

        // exact entry, masked entry, and an overlapping masked entry above it
        loadWrite(ADDR_WIDTH'(2), 16'hA5A5, 16'hFFFF);
        issue(1'b1, 1'b0, 1'b0);
        loadWrite(ADDR_WIDTH'(5), 16'h1200, 16'hFF00);
        issue(1'b1, 1'b0, 1'b0);
        loadWrite(ADDR_WIDTH'(9), 16'h12F0, 16'hFFF0);
        issue(1'b1, 1'b0, 1'b0);
        for (int i = 0; i < NUM_MATCH; i++) begin
            for (int k = 0; k < MVB_ITEMS; k++) begin
                matchData[k] = pickKey();
            end
            matchVld = MVB_ITEMS'($urandom);
            issue(1'b0, 1'b0, 1'b1);
        end

        // random fill, then read back
        for (int i = 0; i < NUM_FILL; i++) begin
            fillAddr[i] = ADDR_WIDTH'($urandom);
            loadWrite(fillAddr[i], DATA_WIDTH'($urandom), DATA_WIDTH'($urandom));
            issue(1'b1, 1'b0, 1'b0);
        end
        for (int i = 0; i < NUM_FILL; i++) begin
            readAddr = fillAddr[i];
            issue(1'b0, 1'b1, 1'b0);
        end

        // all three requests at once, read and match wait for the write
        for (int i = 0; i < NUM_CONTEND; i++) begin
            loadWrite(ADDR_WIDTH'($urandom), DATA_WIDTH'($urandom), 16'hFFFF);
            readAddr  = writeAddr;
            matchData = {MVB_ITEMS{writeData}};
            matchVld  = '1;
            issue(1'b1, 1'b1, 1'b1);
        end

        // mostly back-to-back matches against overlapping entries
        for (int i = 0; i < RAND_CYCLES; i++) begin
            loadWrite(ADDR_WIDTH'($urandom), {8'h12, 8'($urandom)}, MASKS[$urandom_range(3)]);
            readAddr = ADDR_WIDTH'($urandom);
            for (int k = 0; k < MVB_ITEMS; k++) begin
                matchData[k] = pickKey();
            end
            matchVld = MVB_ITEMS'($urandom);
            doW = ($urandom_range(3) == 0);
            doR = ($urandom_range(3) == 0);
            doM = ($urandom_range(3) != 0);
            if (doW || doR || doM) begin
                issue(doW, doR, doM);
            end else begin
                @(negedge CLK);
            end
        end

        repeat (MATCH_LATENCY + 2) @(negedge CLK);
        if (readQ.size() != 0 || matchQ.size() != 0) begin
            errCount++;
            $display("expected results were still pending at the end of the run");
        end
        $display("checks done, %0d errors", errCount);
        if (errCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin : watchdog
        #((STIM_CYCLES + 50) * CLK_PERIOD);
        $display("timeout, the stimulus did not finish within %0d cycles", STIM_CYCLES + 50);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/mvbTcam.sv
// top level of the TCAM with a multi-item match bus
// access control, entry storage, one match lane per bus item
// valid pipeline that tracks accepted match words through the lanes

`timescale 1ns/1ps
`default_nettype none

module mvbTcam import tcamPkg::*; (
    input  wire logic                              CLK,
    input  wire logic                              arstN,

    // write request
    input  wire logic                              writeEn,
    input  wire logic [DATA_WIDTH-1:0]             writeData,
    input  wire logic [DATA_WIDTH-1:0]             writeMask,
    input  wire logic [ADDR_WIDTH-1:0]             writeAddr,
    output logic                                   writeRdy,

    // read request and result
    input  wire logic                              readEn,
    input  wire logic [ADDR_WIDTH-1:0]             readAddr,
    output logic                                   readRdy,
    output logic      [DATA_WIDTH-1:0]             readData,
    output logic      [DATA_WIDTH-1:0]             readMask,
    output logic                                   readDataVld,

    // match request
    input  wire logic                              matchSrcRdy,
    input  wire logic [MVB_ITEMS-1:0][DATA_WIDTH-1:0] matchData,
    input  wire logic [MVB_ITEMS-1:0]              matchVld,
    output logic                                   matchRdy,

    // match result, one field per key
    output logic                                   matchOutSrcRdy,
    output logic      [MVB_ITEMS-1:0]              matchOutVld,
    output logic      [MVB_ITEMS-1:0]              matchOutHit,
    output logic      [MVB_ITEMS-1:0][ADDR_WIDTH-1:0] matchOutAddr
);

    portGrant_t grant;
    logic       matchAccept;

    logic [ITEMS-1:0][DATA_WIDTH-1:0] entryData;
    logic [ITEMS-1:0][DATA_WIDTH-1:0] entryMask;
    logic [ITEMS-1:0]                 entryValid;

    // one slot per lane stage
    logic [MATCH_LATENCY-1:0]                acceptPipe;
    logic [MATCH_LATENCY-1:0][MVB_ITEMS-1:0] vldPipe;

    tcamAccessCtrl i_tcamAccessCtrl (
        .CLK         (CLK),
        .arstN       (arstN),
        .writeEn     (writeEn),
        .readEn      (readEn),
        .matchSrcRdy (matchSrcRdy),
        .writeRdy    (writeRdy),
        .readRdy     (readRdy),
        .matchRdy    (matchRdy),
        .grant       (grant),
        .matchAccept (matchAccept)
    );

    tcamStorage i_tcamStorage (
        .CLK         (CLK),
        .arstN       (arstN),
        .grant       (grant),
        .writeData   (writeData),
        .writeMask   (writeMask),
        .writeAddr   (writeAddr),
        .readAddr    (readAddr),
        .readData    (readData),
        .readMask    (readMask),
        .readDataVld (readDataVld),
        .entryData   (entryData),
        .entryMask   (entryMask),
        .entryValid  (entryValid)
    );

    for (genvar i = 0; i < MVB_ITEMS; i++) begin : g_lane
        tcamMatchLane i_tcamMatchLane (
            .CLK        (CLK),
            .arstN      (arstN),
            .key        (matchData[i]),
            .entryData  (entryData),
            .entryMask  (entryMask),
            .entryValid (entryValid),
            .accept     (matchAccept),
            .hit        (matchOutHit[i]),
            .hitAddr    (matchOutAddr[i])
        );
    end

    // word accepted at edge N shows up at edge N + MATCH_LATENCY,
    // in step with the lane registers
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            acceptPipe <= '0;
            vldPipe    <= '0;
        end else begin
            acceptPipe[0] <= matchAccept;
            vldPipe[0]    <= matchAccept ? matchVld : '0;
            for (int s = 1; s < MATCH_LATENCY; s++) begin
                acceptPipe[s] <= acceptPipe[s-1];
                vldPipe[s]    <= vldPipe[s-1];
            end
        end
    end

    assign matchOutSrcRdy = acceptPipe[MATCH_LATENCY-1];
    assign matchOutVld    = vldPipe[MATCH_LATENCY-1];

    // item valids only travel with a bus word
    assert property (@(posedge CLK) disable iff (!arstN)
        !matchOutSrcRdy |-> matchOutVld == '0)
        else $error("matchOutVld set without matchOutSrcRdy");

endmodule

`default_nettype wire

// File: verilog/tcamMatchLane.sv
// one match lane: ternary compare of a key against every entry
// stage one holds the per-entry match vector
// stage two holds hit and the lowest matching address

`timescale 1ns/1ps
`default_nettype none

module tcamMatchLane import tcamPkg::*; (
    input  wire logic                            CLK,
    input  wire logic                            arstN,

    input  wire logic [DATA_WIDTH-1:0]           key,
    input  wire logic [ITEMS-1:0][DATA_WIDTH-1:0] entryData,
    input  wire logic [ITEMS-1:0][DATA_WIDTH-1:0] entryMask,
    input  wire logic [ITEMS-1:0]                entryValid,
    input  wire logic                            accept,

    output logic                                 hit,
    output logic      [ADDR_WIDTH-1:0]           hitAddr
);

    logic [ITEMS-1:0]      matchNow;
    logic [ITEMS-1:0]      matchVec;
    logic                  nextHit;
    logic [ADDR_WIDTH-1:0] nextAddr;

    // masked-off bits never cause a mismatch
    always_comb begin
        for (int i = 0; i < ITEMS; i++) begin
            matchNow[i] = entryValid[i] &&
                          (((key ^ entryData[i]) & entryMask[i]) == '0);
        end
    end

    // stage one, loaded only on an accepted match word
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            matchVec <= '0;
        end else if (accept) begin
            matchVec <= matchNow;
        end
    end

    // lowest index wins, so scan from the top down
    always_comb begin
        nextHit  = |matchVec;
        nextAddr = '0;
        for (int i = ITEMS - 1; i >= 0; i--) begin
            if (matchVec[i]) begin
                nextAddr = ADDR_WIDTH'(i);
            end
        end
    end

    // stage two
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            hit     <= 1'b0;
            hitAddr <= '0;
        end else begin
            hit     <= nextHit;
            hitAddr <= nextAddr;
        end
    end

    // a miss always reports address zero
    assert property (@(posedge CLK) disable iff (!arstN)
        !hit |-> hitAddr == '0)
        else $error("hitAddr nonzero without a hit");

endmodule

`default_nettype wire

// File: verilog/tcamStorage.sv
// TCAM entry array: data, care mask and valid bit per entry
// granted write port, registered read port with valid flag
// flat view of all entries for the match lanes

`timescale 1ns/1ps
`default_nettype none

module tcamStorage import tcamPkg::*; (
    input  wire logic                  CLK,
    input  wire logic                  arstN,

    input  wire portGrant_t            grant,

    // write port
    input  wire logic [DATA_WIDTH-1:0] writeData,
    input  wire logic [DATA_WIDTH-1:0] writeMask,
    input  wire logic [ADDR_WIDTH-1:0] writeAddr,

    // read port
    input  wire logic [ADDR_WIDTH-1:0] readAddr,
    output logic      [DATA_WIDTH-1:0] readData,
    output logic      [DATA_WIDTH-1:0] readMask,
    output logic                       readDataVld,

    // all entries, index i is entry address i
    output logic [ITEMS-1:0][DATA_WIDTH-1:0] entryData,
    output logic [ITEMS-1:0][DATA_WIDTH-1:0] entryMask,
    output logic [ITEMS-1:0]                 entryValid
);

    logic writeGo;
    logic readGo;

    assign writeGo = (grant == PORT_WRITE);
    assign readGo  = (grant == PORT_READ);

    // entry payload
    always_ff @(posedge CLK) begin
        if (writeGo) begin
            entryData[writeAddr] <= writeData;
            entryMask[writeAddr] <= writeMask;
        end
    end

    // entries become valid on their first write
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            entryValid <= '0;
        end else if (writeGo) begin
            entryValid[writeAddr] <= 1'b1;
        end
    end

    // read data, zero for an entry never written
    always_ff @(posedge CLK) begin
        if (readGo) begin
            if (entryValid[readAddr]) begin
                readData <= entryData[readAddr];
                readMask <= entryMask[readAddr];
            end else begin
                readData <= '0;
                readMask <= '0;
            end
        end
    end

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            readDataVld <= 1'b0;
        end else begin
            readDataVld <= readGo;
        end
    end

    // one read result per read grant, exactly one cycle later
    assert property (@(posedge CLK) disable iff (!arstN)
        readDataVld == $past(grant == PORT_READ))
        else $error("readDataVld out of step with the read grant");

endmodule

`default_nettype wire

// File: verilog/tcamAccessCtrl.sv
// request arbitration for the TCAM storage port and the match path
// write beats read on the shared port, match blocked per policy flag

`timescale 1ns/1ps
`default_nettype none

module tcamAccessCtrl import tcamPkg::*; (
    input  wire logic CLK,
    input  wire logic arstN,

    input  wire logic writeEn,
    input  wire logic readEn,
    input  wire logic matchSrcRdy,

    output logic       writeRdy,
    output logic       readRdy,
    output logic       matchRdy,
    output portGrant_t grant,
    output logic       matchAccept
);

    logic [STARVE_WIDTH-1:0] starveCnt;

    // a write only waits on a match when the policy favours matches
    assign writeRdy = WRITE_BEFORE_MATCH ? 1'b1 : !matchSrcRdy;

    // write owns the port whenever it is requested
    assign readRdy = !writeEn;

    // contents stay frozen in the cycle a match word is sampled
    assign matchRdy = WRITE_BEFORE_MATCH ? !writeEn : 1'b1;

    assign matchAccept = matchSrcRdy && matchRdy;

    always_comb begin
        if (writeEn && writeRdy) begin
            grant = PORT_WRITE;
        end else if (readEn && readRdy) begin
            grant = PORT_READ;
        end else begin
            grant = PORT_IDLE;
        end
    end

    // consecutive cycles a read request waited behind a write
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            starveCnt <= '0;
        end else if (readEn && !readRdy) begin
            if (starveCnt != '1) begin
                starveCnt <= starveCnt + 1'b1;
            end
        end else begin
            starveCnt <= '0;
        end
    end

    // the shared port never goes to a read while a write is pending
    assert property (@(posedge CLK) disable iff (!arstN)
        writeEn |-> grant != PORT_READ)
        else $error("read granted while writeEn is high");

    // a read never waits long enough to saturate the starvation count
    assert property (@(posedge CLK) disable iff (!arstN)
        starveCnt != '1)
        else $error("read request starved by a long run of writes");

endmodule

`default_nettype wire

// File: verilog/tcamPkg.sv
// shared sizes for the TCAM with a multi-item match bus
// write-before-match policy flag
// storage access port grant encoding

`default_nettype none

package tcamPkg;

    // key, entry data and entry mask width
    localparam int DATA_WIDTH = 16;

    // entry count and address width
    localparam int ITEMS      = 16;
    localparam int ADDR_WIDTH = $clog2(ITEMS);

    // keys carried per match bus word
    localparam int MVB_ITEMS = 2;

    // edges from match acceptance to the edge where the result is sampled
    localparam int MATCH_LATENCY = 2;

    // when set a pending write holds off match acceptance
    // when clear a pending match holds off the write
    localparam bit WRITE_BEFORE_MATCH = 1'b1;

    // saturating counter width for read starvation tracking
    localparam int STARVE_WIDTH = 4;

    // owner of the storage access port in a cycle
    typedef enum logic [1:0] {
        PORT_IDLE  = 2'd0,
        PORT_WRITE = 2'd1,
        PORT_READ  = 2'd2
    } portGrant_t;

endpackage

`default_nettype wire
